// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module rvCoreTb -o simv

output=$(./obj_dir/simv || true)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
	import rvPkg::*;
(
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [3:0] aluOp,
	input  logic [2:0] funct3,
	output logic [31:0] result,
	output logic branchTaken
);

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSll: result = a << b[4:0];
			aluSrl: result = a >> b[4:0];
			aluSra: result = $signed(a) >>> b[4:0];
			aluSlt: result = {31'd0, lessSigned};
			aluSltu: result = {31'd0, lessUnsigned};
			default: result = '0;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: branchTaken = (a == b); // beq
			3'b001: branchTaken = (a != b);
			3'b100: branchTaken = lessSigned;
			3'b101: branchTaken = !lessSigned;
			3'b110: branchTaken = lessUnsigned;
			3'b111: branchTaken = !lessUnsigned;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: src/controlFsm.sv
`timescale 1ns/1ps

module controlFsm
	import rvPkg::*;
(
	input  logic CLK,
	input  logic rstN,
	input  instrWord instr,
	input  logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic irWrite,
	output logic oldPcWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic [1:0] aSel,
	output logic [1:0] bSel,
	output logic [3:0] aluOp,
	output logic aluWrite,
	output logic rfWrite,
	output logic wbFromMem,
	output logic addrFromAlu,
	output logic [31:0] retiredCount
);

	logic [3:0] state;
	logic [3:0] nextState;
	logic [3:0] fieldOp;
	logic busNext;
	logic retire;

	always_comb begin
		case (instr.rType.funct3)
			3'b000: fieldOp = (instr.rType.opcode == opReg && instr.rType.funct7[5]) ?
				aluSub : aluAdd; // No subi
			3'b001: fieldOp = aluSll;
			3'b010: fieldOp = aluSlt;
			3'b011: fieldOp = aluSltu;
			3'b100: fieldOp = aluXor;
			3'b101: fieldOp = instr.rType.funct7[5] ? aluSra : aluSrl;
			3'b110: fieldOp = aluOr;
			default: fieldOp = aluAnd;
		endcase
	end

	always_comb begin
		case (state)
			stFetch: nextState = wbAck ? stDecode : stFetch;
			stDecode: begin
				case (instr.rType.opcode)
					opReg: nextState = stExecReg;
					opImm: nextState = stExecImm;
					opLoad, opStore: nextState = stAddrCalc;
					opBranch: nextState = stBranch;
					opJal: nextState = stJal;
					opJalr: nextState = stJalr;
					default: nextState = stFetch; // Unknown opcode is a no-op
				endcase
			end
			stExecReg, stExecImm, stBranch, stJalr: nextState = stWriteBack;
			stAddrCalc: nextState = (instr.rType.opcode == opLoad) ? stMemLoad : stMemStore;
			stMemLoad: nextState = wbAck ? stWriteBack : stMemLoad;
			stMemStore: nextState = wbAck ? stFetch : stMemStore;
			default: nextState = stFetch; // Jal and write-back end here
		endcase
	end

	always_comb begin
		irWrite = 1'b0;
		oldPcWrite = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		aSel = aSelOldPc;
		bSel = bSelFour;
		aluWrite = 1'b0;
		rfWrite = 1'b0;
		wbFromMem = 1'b0;
		addrFromAlu = 1'b0;
		aluOp = aluAdd;
		case (state)
			stFetch: begin
				irWrite = wbAck;
				oldPcWrite = wbAck;
				pcWrite = wbAck; // PC + 4
				aSel = aSelPc;
			end
			stDecode: aluWrite = 1'b1; // Return address oldPc + 4
			stExecReg: begin
				aSel = aSelRs1;
				bSel = bSelRs2;
				aluOp = fieldOp;
				aluWrite = 1'b1;
			end
			stExecImm: begin
				aSel = aSelRs1;
				bSel = bSelImm;
				aluOp = fieldOp;
				aluWrite = 1'b1;
			end
			stAddrCalc: begin
				aSel = aSelRs1;
				bSel = bSelImm;
				aluWrite = 1'b1;
			end
			stBranch: begin
				bSel = bSelImm; // Target into aluOut
				aluWrite = 1'b1;
			end
			stJal: begin
				bSel = bSelImm;
				pcWrite = 1'b1;
				rfWrite = 1'b1;
			end
			stJalr: begin
				aSel = aSelRs1;
				bSel = bSelImm;
				pcWrite = 1'b1;
			end
			stMemLoad, stMemStore: addrFromAlu = 1'b1;
			stWriteBack: begin
				if (instr.rType.opcode == opBranch) begin
					aSel = aSelRs1; // Branch resolves here
					bSel = bSelRs2;
					pcWriteCond = 1'b1;
				end else begin
					rfWrite = 1'b1;
					wbFromMem = (instr.rType.opcode == opLoad);
				end
			end
			default: aluOp = aluAdd;
		endcase
	end

	assign busNext = (nextState == stFetch) || (nextState == stMemLoad) ||
		(nextState == stMemStore);
	assign retire = (state == stWriteBack) || (state == stJal) ||
		(state == stMemStore && wbAck) || (state == stDecode && nextState == stFetch);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= stFetch;
			wbCyc <= 1'b0;
			wbWe <= 1'b0;
			retiredCount <= '0;
		end else begin
			state <= nextState;
			wbCyc <= busNext && !wbAck; // Drops the cycle after ack
			wbWe <= (nextState == stMemStore);
			if (retire)
				retiredCount <= retiredCount + 32'd1;
		end
	end

	assign wbStb = wbCyc; // Single transfers only

endmodule

// File: src/datapath.sv
`timescale 1ns/1ps

module datapath
	import rvPkg::*;
(
	input  logic CLK,
	input  logic rstN,
	input  logic irWrite,
	input  logic oldPcWrite,
	input  logic pcWrite,
	input  logic pcWriteCond,
	input  logic [1:0] aSel,
	input  logic [1:0] bSel,
	input  logic [3:0] aluOp,
	input  logic aluWrite,
	input  logic rfWrite,
	input  logic wbFromMem,
	input  logic addrFromAlu,
	input  logic [31:0] wbDatR,
	input  logic wbAck,
	output instrWord instr,
	output logic [31:0] wbAdr,
	output logic [3:0] wbSel,
	output logic [31:0] wbDatW
);

	logic [31:0] pc;
	logic [31:0] oldPc;
	logic [31:0] aReg;
	logic [31:0] bReg;
	logic [31:0] aluOut;
	logic [31:0] memData;
	logic [31:0] rdData1;
	logic [31:0] rdData2;
	logic [31:0] imm;
	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic [31:0] pcNext;
	logic branchTaken;

	regFile regs_i (
		.CLK(CLK),
		.rstN(rstN),
		.rs1(instr.rType.rs1),
		.rs2(instr.rType.rs2),
		.rd(instr.rType.rd),
		.wrEn(rfWrite),
		.wrData(wbFromMem ? memData : aluOut),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	immGen imm_i (
		.instr(instr),
		.imm(imm)
	);

	always_comb begin
		case (aSel)
			aSelPc: aluA = pc;
			aSelOldPc: aluA = oldPc;
			aSelRs1: aluA = aReg;
			default: aluA = '0;
		endcase
		case (bSel)
			bSelRs2: aluB = bReg;
			bSelImm: aluB = imm;
			bSelFour: aluB = 32'd4;
			default: aluB = '0;
		endcase
	end

	aluUnit alu_i (
		.a(aluA),
		.b(aluB),
		.aluOp(aluOp),
		.funct3(instr.rType.funct3),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	// Branch target waits in aluOut, bit 0 cleared for jalr
	assign pcNext = pcWriteCond ? aluOut : {aluResult[31:1], 1'b0};

	always_ff @(posedge CLK) begin
		if (!rstN)
			pc <= '0;
		else if (pcWrite || (pcWriteCond && branchTaken))
			pc <= pcNext;
	end

	always_ff @(posedge CLK) begin
		if (irWrite)
			instr <= wbDatR;
		if (oldPcWrite)
			oldPc <= pc;
		if (aluWrite)
			aluOut <= aluResult;
		if (wbAck)
			memData <= wbDatR;
		if (aluWrite) begin // Held through bus waits
			aReg <= rdData1;
			bReg <= rdData2;
		end
	end

	assign wbAdr = addrFromAlu ? aluOut : pc;
	assign wbSel = 4'hf; // Word accesses only
	assign wbDatW = bReg;

endmodule

// File: src/immGen.sv
`timescale 1ns/1ps

module immGen
	import rvPkg::*;
(
	input  instrWord instr,
	output logic [31:0] imm
);

	always_comb begin
		case (instr.rType.opcode)
			opImm, opLoad, opJalr: begin
				imm = {{20{instr.iType.imm11_0[11]}}, instr.iType.imm11_0};
			end
			opStore: begin
				imm = {{20{instr.sType.imm11_5[6]}}, instr.sType.imm11_5,
					instr.sType.imm4_0};
			end
			opBranch: begin
				imm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
					instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
			end
			opJal: begin
				imm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19_12,
					instr.jType.imm11, instr.jType.imm10_1, 1'b0};
			end
			default: imm = '0; // R type has no immediate
		endcase
	end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic CLK,
	input  logic rstN,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic [4:0] rd,
	input  logic wrEn,
	input  logic [31:0] wrData,
	output logic [31:0] rdData1,
	output logic [31:0] rdData2
);

	logic [31:0] regs [32];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && rd != 5'd0) begin
			regs[rd] <= wrData;
		end
	end

	// x0 reads as zero
	assign rdData1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rdData2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: src/rvCore.sv
`timescale 1ns/1ps

module rvCore
	import rvPkg::*;
(
	input  logic CLK,
	input  logic rstN,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [31:0] wbAdr,
	output logic [3:0] wbSel,
	output logic [31:0] wbDatW,
	input  logic [31:0] wbDatR,
	input  logic wbAck,
	output logic [31:0] retiredCount
);

	instrWord instr;
	logic irWrite;
	logic oldPcWrite;
	logic pcWrite;
	logic pcWriteCond;
	logic [1:0] aSel;
	logic [1:0] bSel;
	logic [3:0] aluOp;
	logic aluWrite;
	logic rfWrite;
	logic wbFromMem;
	logic addrFromAlu;

	controlFsm fsm_i (
		.CLK(CLK),
		.rstN(rstN),
		.instr(instr),
		.wbAck(wbAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.irWrite(irWrite),
		.oldPcWrite(oldPcWrite),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.aSel(aSel),
		.bSel(bSel),
		.aluOp(aluOp),
		.aluWrite(aluWrite),
		.rfWrite(rfWrite),
		.wbFromMem(wbFromMem),
		.addrFromAlu(addrFromAlu),
		.retiredCount(retiredCount)
	);

	datapath dp_i (
		.CLK(CLK),
		.rstN(rstN),
		.irWrite(irWrite),
		.oldPcWrite(oldPcWrite),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.aSel(aSel),
		.bSel(bSel),
		.aluOp(aluOp),
		.aluWrite(aluWrite),
		.rfWrite(rfWrite),
		.wbFromMem(wbFromMem),
		.addrFromAlu(addrFromAlu),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.instr(instr),
		.wbAdr(wbAdr),
		.wbSel(wbSel),
		.wbDatW(wbDatW)
	);

endmodule

// File: src/rvPkg.sv
package rvPkg;

	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;

	localparam logic [3:0] aluAdd  = 4'd0;
	localparam logic [3:0] aluSub  = 4'd1;
	localparam logic [3:0] aluAnd  = 4'd2;
	localparam logic [3:0] aluOr   = 4'd3;
	localparam logic [3:0] aluXor  = 4'd4;
	localparam logic [3:0] aluSll  = 4'd5;
	localparam logic [3:0] aluSrl  = 4'd6;
	localparam logic [3:0] aluSra  = 4'd7;
	localparam logic [3:0] aluSlt  = 4'd8;
	localparam logic [3:0] aluSltu = 4'd9;

	localparam logic [3:0] stFetch     = 4'd0;
	localparam logic [3:0] stDecode    = 4'd1;
	localparam logic [3:0] stExecReg   = 4'd2;
	localparam logic [3:0] stExecImm   = 4'd3;
	localparam logic [3:0] stAddrCalc  = 4'd4;
	localparam logic [3:0] stBranch    = 4'd5;
	localparam logic [3:0] stJal       = 4'd6;
	localparam logic [3:0] stJalr      = 4'd7;
	localparam logic [3:0] stMemLoad   = 4'd8;
	localparam logic [3:0] stMemStore  = 4'd9;
	localparam logic [3:0] stWriteBack = 4'd10;

	localparam logic [1:0] aSelPc    = 2'd0;
	localparam logic [1:0] aSelOldPc = 2'd1;
	localparam logic [1:0] aSelRs1   = 2'd2;

	localparam logic [1:0] bSelRs2  = 2'd0;
	localparam logic [1:0] bSelImm  = 2'd1;
	localparam logic [1:0] bSelFour = 2'd2;

	// One instruction word seen in each RV32I format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm11_0;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} iType;
		struct packed {
			logic [6:0] imm11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm4_0;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} instrWord;

endpackage

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK; // 20 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

// File: test/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;
	import rvPkg::*;

	localparam logic [31:0] doneAddr = 32'h0000_07fc;
	localparam int timeoutCycles = 20000;

	logic CLK;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [31:0] wbAdr;
	logic [3:0] wbSel;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR = 32'd0;
	logic wbAck = 1'b0;
	logic [31:0] retiredCount;

	logic [31:0] mem [1024];
	logic [31:0] refMem [1024];
	logic [31:0] expAdr [$];
	logic [31:0] expDat [$];
	logic [31:0] rng;
	int refCount;
	int progIdx;
	int storeOff;
	int expIdx = 0;
	int waitLeft = 0;
	bit pending = 1'b0;
	bit doneSeen = 1'b0;
	bit doneChecked = 1'b0;
	bit firstSeen = 1'b0;
	int resetEdges = 0;
	logic prevPend = 1'b0;
	logic prevAck = 1'b0;
	logic [31:0] prevAdr;
	logic [31:0] prevDat;
	logic prevWe;

	clockGen clk_i (.CLK(CLK), .rstN(rstN));

	rvCore dut_i (
		.CLK(CLK),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbSel(wbSel),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.retiredCount(retiredCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rEnc(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iEnc(input int imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sEnc(input int imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bEnc(input int imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jEnc(input int imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	task automatic put(input logic [31:0] w);
		mem[progIdx] = w;
		progIdx++;
	endtask

	task automatic storeReg(input logic [4:0] r);
		put(sEnc(storeOff, r, 5'd10)); // Result area at x10
		storeOff += 4;
	endtask

	task automatic aluStore(input logic [31:0] w);
		put(w);
		storeReg(5'd8);
	endtask

	task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		put(iEnc(1, 5'd20, 3'b001, 5'd20, opImm)); // Shift the record left
		put(bEnc(8, rs2, rs1, f3));
		put(iEnc(1, 5'd20, 3'b000, 5'd20, opImm)); // Skipped when taken
	endtask

	task automatic loadProgram();
		int p;
		progIdx = 0;
		storeOff = 0;
		put(iEnc(12'h400, 5'd0, 3'b010, 5'd1, opLoad));
		put(iEnc(12'h404, 5'd0, 3'b010, 5'd2, opLoad));
		put(iEnc(-5, 5'd0, 3'b000, 5'd3, opImm));
		put(iEnc(7, 5'd0, 3'b000, 5'd4, opImm));
		put(iEnc(12'h600, 5'd0, 3'b000, 5'd10, opImm));
		aluStore(rEnc(7'h00, 5'd2, 5'd1, 3'b000, 5'd8));
		aluStore(rEnc(7'h20, 5'd2, 5'd1, 3'b000, 5'd8));
		aluStore(rEnc(7'h00, 5'd2, 5'd1, 3'b111, 5'd8));
		aluStore(rEnc(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
		aluStore(rEnc(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
		aluStore(rEnc(7'h00, 5'd2, 5'd1, 3'b001, 5'd8));
		aluStore(rEnc(7'h00, 5'd4, 5'd3, 3'b101, 5'd8));
		aluStore(rEnc(7'h20, 5'd4, 5'd3, 3'b101, 5'd8));
		aluStore(rEnc(7'h00, 5'd4, 5'd3, 3'b010, 5'd8));
		aluStore(rEnc(7'h00, 5'd4, 5'd3, 3'b011, 5'd8));
		aluStore(iEnc(-123, 5'd1, 3'b000, 5'd8, opImm));
		aluStore(iEnc(12'h0f0, 5'd1, 3'b111, 5'd8, opImm));
		aluStore(iEnc(-256, 5'd1, 3'b110, 5'd8, opImm));
		aluStore(iEnc(12'h555, 5'd1, 3'b100, 5'd8, opImm));
		aluStore(iEnc(3, 5'd1, 3'b001, 5'd8, opImm));
		aluStore(iEnc(4, 5'd3, 3'b101, 5'd8, opImm));
		aluStore(iEnc(12'h404, 5'd3, 3'b101, 5'd8, opImm)); // srai
		aluStore(iEnc(1, 5'd3, 3'b010, 5'd8, opImm));
		aluStore(iEnc(1, 5'd3, 3'b011, 5'd8, opImm));
		// Round trip through memory
		put(sEnc(12'h100, 5'd2, 5'd10));
		put(iEnc(12'h100, 5'd10, 3'b010, 5'd8, opLoad));
		storeReg(5'd8);
		branchCase(3'b000, 5'd3, 5'd3);
		branchCase(3'b000, 5'd3, 5'd4);
		branchCase(3'b001, 5'd3, 5'd4);
		branchCase(3'b001, 5'd3, 5'd3);
		branchCase(3'b100, 5'd3, 5'd4);
		branchCase(3'b100, 5'd4, 5'd3);
		branchCase(3'b101, 5'd4, 5'd3);
		branchCase(3'b101, 5'd3, 5'd4);
		branchCase(3'b110, 5'd4, 5'd3);
		branchCase(3'b110, 5'd3, 5'd4);
		branchCase(3'b111, 5'd3, 5'd4);
		branchCase(3'b111, 5'd4, 5'd3);
		storeReg(5'd20);
		// Counted loop, four stores
		put(iEnc(4, 5'd0, 3'b000, 5'd6, opImm));
		put(iEnc(0, 5'd0, 3'b000, 5'd7, opImm));
		put(iEnc(12'h700, 5'd0, 3'b000, 5'd11, opImm));
		put(iEnc(1, 5'd7, 3'b000, 5'd7, opImm));
		put(sEnc(0, 5'd7, 5'd11));
		put(iEnc(4, 5'd11, 3'b000, 5'd11, opImm));
		put(bEnc(-12, 5'd6, 5'd7, 3'b001));
		put(jEnc(8, 5'd12));
		put(iEnc(0, 5'd0, 3'b000, 5'd20, opImm));
		storeReg(5'd12);
		p = progIdx;
		put(iEnc((p + 3) * 4 - 1, 5'd0, 3'b000, 5'd13, opImm));
		put(iEnc(2, 5'd13, 3'b000, 5'd14, opJalr)); // Odd target, bit 0 dropped
		put(iEnc(0, 5'd0, 3'b000, 5'd20, opImm));
		storeReg(5'd14);
		put(32'h0000_0073); // Unsupported, retires as no-op
		put(iEnc(1, 5'd0, 3'b000, 5'd21, opImm));
		put(sEnc(12'h7fc, 5'd21, 5'd0));
		put(jEnc(0, 5'd0));
	endtask

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic isReg, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return (isReg && alt) ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Runs the program on refMem, returns instructions retired through the done store
	function automatic int runReference();
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic [31:0] link;
		logic [4:0] rd;
		logic [2:0] f3;
		logic [31:0] v1;
		logic [31:0] v2;
		logic take;
		int count;
		for (int i = 0; i < 32; i++)
			x[i] = 32'd0;
		pc = 32'd0;
		count = 0;
		while (count < 10000) begin
			ins = refMem[pc[11:2]];
			rd = ins[11:7];
			f3 = ins[14:12];
			v1 = x[ins[19:15]];
			v2 = x[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			count++;
			link = pc + 32'd4;
			pc = link;
			case (ins[6:0])
				opReg: x[rd] = aluRef(f3, ins[30], 1'b1, v1, v2);
				opImm: x[rd] = aluRef(f3, ins[30], 1'b0, v1, immI);
				opLoad: x[rd] = refMem[(v1 + immI) >> 2];
				opStore: begin
					addr = v1 + immS;
					refMem[addr[11:2]] = v2;
					expAdr.push_back(addr);
					expDat.push_back(v2);
					if (addr == doneAddr)
						return count;
				end
				opBranch: begin
					case (f3)
						3'b000: take = (v1 == v2);
						3'b001: take = (v1 != v2);
						3'b100: take = $signed(v1) < $signed(v2);
						3'b101: take = $signed(v1) >= $signed(v2);
						3'b110: take = v1 < v2;
						3'b111: take = v1 >= v2;
						default: take = 1'b0;
					endcase
					if (take)
						pc = link - 32'd4 + immB;
				end
				opJal: begin
					pc = link - 32'd4 + immJ;
					x[rd] = link;
				end
				opJalr: begin
					pc = (v1 + immI) & ~32'd1;
					x[rd] = link;
				end
				default: pc = link;
			endcase
			x[0] = 32'd0;
		end
		return -1;
	endfunction

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	initial begin
		rng = 32'h521b_2b57;
		for (int i = 0; i < 1024; i++) begin
			rng = xorshift(rng);
			mem[i] = rng;
		end
		loadProgram();
		refMem = mem;
		refCount = runReference();
	end

	// Wishbone slave with random wait states
	always @(posedge CLK) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			pending = 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!pending) begin
				rng = xorshift(rng);
				waitLeft = int'(rng[1:0]);
				pending = 1'b1;
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				wbAck <= 1'b1;
				if (wbWe)
					mem[wbAdr[11:2]] = wbDatW;
				else
					wbDatR <= mem[wbAdr[11:2]];
			end else begin
				waitLeft--;
			end
		end
	end

	// Bus protocol and store comparison
	always @(posedge CLK) begin
		if (!rstN) begin
			if (resetEdges > 0)
				assert (!wbCyc && !wbStb) else
					fail($sformatf("error %0t: bus active during reset", $time));
			resetEdges++;
		end else begin
			if (!firstSeen && wbCyc && wbStb) begin
				firstSeen = 1'b1;
				assert (!wbWe && wbAdr == 32'd0) else
					fail($sformatf("error %0t: first access not a read at 0", $time));
			end
			if (prevPend)
				assert (wbCyc && wbStb && wbAdr == prevAdr && wbWe == prevWe &&
					wbDatW == prevDat) else
					fail($sformatf("error %0t: master outputs changed before ack", $time));
			if (prevAck)
				assert (!wbCyc && !wbStb) else
					fail($sformatf("error %0t: bus cycle not dropped after ack", $time));
			prevPend <= wbCyc && wbStb && !wbAck;
			prevAck <= wbAck;
			prevAdr <= wbAdr;
			prevWe <= wbWe;
			prevDat <= wbDatW;
			if (doneSeen && !doneChecked) begin
				assert (retiredCount == 32'(refCount)) else
					fail($sformatf("error %0t: retiredCount %0d, expected %0d", $time,
						retiredCount, refCount));
				doneChecked = 1'b1;
			end
			if (wbCyc && wbStb && wbWe && wbAck && !doneSeen) begin
				assert (expIdx < expAdr.size()) else
					fail($sformatf("error %0t: unexpected store to %h", $time, wbAdr));
				assert (wbAdr == expAdr[expIdx] && wbDatW == expDat[expIdx] &&
					wbSel == 4'hf) else
					fail($sformatf("error %0t: store %0d got %h <= %h, expected %h <= %h",
						$time, expIdx, wbAdr, wbDatW, expAdr[expIdx], expDat[expIdx]));
				expIdx++;
				if (wbAdr == doneAddr)
					doneSeen = 1'b1;
			end
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		#1;
		if (refCount < 0)
			fail("reference model never reached the done store");
		while (!doneChecked && cycles < timeoutCycles) begin
			@(posedge CLK);
			cycles++;
		end
		#1;
		if (doneChecked) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail("timeout waiting for the store to the done address");
		end
	end

endmodule

// File: vlog.f
src/rvPkg.sv
src/aluUnit.sv
src/regFile.sv
src/immGen.sv
src/controlFsm.sv
src/datapath.sv
src/rvCore.sv
test/clockGen.sv
test/rvCoreTb.sv
